//--- dual_execute.f
+incdir+rtl
rtl/execute_pkg.sv
rtl/lane_result_if.sv
rtl/exec_lane.sv
rtl/issue_merge.sv
rtl/dual_execute.sv
testbench/dual_execute_sva.sv
testbench/dual_execute_tb.sv

//--- rtl/dual_execute.sv
`timescale 1ns/1ps
`include "execute_settings.svh"

module dual_execute (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  logic                  in0_valid,        // older insn
    input  execute_pkg::op_t      in0_op,
    input  logic                  in0_use_imm,
    input  logic [`XLEN-1:0]      in0_pc,
    input  logic [`XLEN-1:0]      in0_rs1,
    input  logic [`XLEN-1:0]      in0_rs2,
    input  logic [`XLEN-1:0]      in0_imm,
    input  logic [`REG_BITS-1:0]  in0_rd,
    input  logic                  in1_valid,        // younger insn
    input  execute_pkg::op_t      in1_op,
    input  logic                  in1_use_imm,
    input  logic [`XLEN-1:0]      in1_pc,
    input  logic [`XLEN-1:0]      in1_rs1,
    input  logic [`XLEN-1:0]      in1_rs2,
    input  logic [`XLEN-1:0]      in1_imm,
    input  logic [`REG_BITS-1:0]  in1_rd,
    output logic                  out0_valid,
    output logic                  out0_wren,
    output logic [`REG_BITS-1:0]  out0_waddr,
    output logic [`XLEN-1:0]      out0_wdata,
    output logic                  out0_exception,
    output execute_pkg::ecause_t  out0_ecause,
    output logic                  out1_valid,
    output logic                  out1_wren,
    output logic [`REG_BITS-1:0]  out1_waddr,
    output logic [`XLEN-1:0]      out1_wdata,
    output logic                  out1_exception,
    output execute_pkg::ecause_t  out1_ecause,
    output logic                  redirect_valid,
    output logic [`XLEN-1:0]      redirect_pc
);
    import execute_pkg::*;

    lane_req_t req0;
    lane_req_t req1;

    assign req0 = '{valid: in0_valid, op: in0_op, use_imm: in0_use_imm, pc: in0_pc,
                    rs1: in0_rs1, rs2: in0_rs2, imm: in0_imm, rd: in0_rd};
    assign req1 = '{valid: in1_valid, op: in1_op, use_imm: in1_use_imm, pc: in1_pc,
                    rs1: in1_rs1, rs2: in1_rs2, imm: in1_imm, rd: in1_rd};

    lane_result_if lane0_res ();
    lane_result_if lane1_res ();

    exec_lane lane0_inst (.req(req0), .res(lane0_res));
    exec_lane lane1_inst (.req(req1), .res(lane1_res));

    issue_merge merge_inst (
        .clock(clock), .reset(reset), .stall(stall), .flush(flush),
        .lane0(lane0_res), .lane1(lane1_res),
        .out0_valid(out0_valid), .out0_wren(out0_wren), .out0_waddr(out0_waddr),
        .out0_wdata(out0_wdata), .out0_exception(out0_exception), .out0_ecause(out0_ecause),
        .out1_valid(out1_valid), .out1_wren(out1_wren), .out1_waddr(out1_waddr),
        .out1_wdata(out1_wdata), .out1_exception(out1_exception), .out1_ecause(out1_ecause),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc)
    );

endmodule

//--- rtl/exec_lane.sv
`timescale 1ns/1ps
`include "execute_settings.svh"

module exec_lane (
    input execute_pkg::lane_req_t req,
    lane_result_if.lane           res
);
    import execute_pkg::*;

    localparam int SHAMT_BITS = $clog2(`XLEN);

    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] npc;
    logic [`XLEN-1:0] address;
    logic [`XLEN-1:0] target;
    logic [`XLEN-1:0] result;
    logic             taken;
    logic             is_jump;
    logic             writes;
    logic             fault;
    ecause_t          cause;

    assign op_b = req.use_imm ? req.imm : req.rs2;
    assign npc = req.pc + `XLEN'(`INSN_BYTES);
    assign address = req.rs1 + req.imm;  // load/store and jalr base

    //////////////////// alu

    always_comb begin
        case (req.op)
            op_add:  alu_result = req.rs1 + op_b;
            op_sub:  alu_result = req.rs1 - op_b;
            op_and:  alu_result = req.rs1 & op_b;
            op_or:   alu_result = req.rs1 | op_b;
            op_xor:  alu_result = req.rs1 ^ op_b;
            op_slt:  alu_result = `XLEN'($signed(req.rs1) < $signed(op_b));
            op_sltu: alu_result = `XLEN'(req.rs1 < op_b);
            op_sll:  alu_result = req.rs1 << op_b[SHAMT_BITS-1:0];
            op_srl:  alu_result = req.rs1 >> op_b[SHAMT_BITS-1:0];
            op_sra:  alu_result = $signed(req.rs1) >>> op_b[SHAMT_BITS-1:0];
            op_lui:  alu_result = req.imm;
            default: alu_result = '0;
        endcase
    end

    //////////////////// branch and target

    always_comb begin
        case (req.op)
            op_beq:  taken = (req.rs1 == req.rs2);
            op_bne:  taken = (req.rs1 != req.rs2);
            op_blt:  taken = ($signed(req.rs1) < $signed(req.rs2));
            op_bge:  taken = ($signed(req.rs1) >= $signed(req.rs2));
            default: taken = 1'b0;
        endcase
    end

    assign is_jump = (req.op == op_jal) | (req.op == op_jalr) | taken;
    assign target = (req.op == op_jalr) ? {address[`XLEN-1:1], 1'b0} : req.pc + req.imm;

    //////////////////// exceptions

    // decode faults first, then address faults
    always_comb begin
        fault = 1'b1;
        cause = cause_inst_misaligned;
        if (req.op == op_illegal) begin
            cause = cause_illegal;
        end else if (req.op == op_ebreak) begin
            cause = cause_breakpoint;
        end else if (req.op == op_ecall) begin
            cause = cause_ecall;
        end else if (req.op == op_load && address[1:0] != 2'b00) begin
            cause = cause_load_misaligned;
        end else if (req.op == op_store && address[1:0] != 2'b00) begin
            cause = cause_store_misaligned;
        end else if (is_jump && target[1]) begin
            cause = cause_inst_misaligned;  // jump cancelled below
        end else begin
            fault = 1'b0;
        end
    end

    //////////////////// write-back

    always_comb begin
        writes = 1'b0;
        case (req.op)
            op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sltu,
            op_sll, op_srl, op_sra, op_lui: begin
                writes = 1'b1;
                result = alu_result;
            end
            op_jal, op_jalr: begin
                writes = 1'b1;
                result = npc;  // link value
            end
            op_load, op_store:             result = address;
            op_ecall, op_ebreak, op_illegal: result = req.pc;
            default:                       result = '0;
        endcase
    end

    assign res.valid = req.valid;
    assign res.wren = req.valid & writes & ~fault & (req.rd != '0);
    assign res.waddr = req.rd;
    assign res.wdata = result;
    assign res.npc = npc;
    assign res.jump = req.valid & is_jump & ~fault;
    assign res.target = target;
    assign res.exception = req.valid & fault;
    assign res.ecause = cause;

endmodule

//--- rtl/execute_pkg.sv
`include "execute_settings.svh"

package execute_pkg;

    //////////////////// operations

    typedef enum logic [4:0] {
        op_add,
        op_sub,
        op_and,
        op_or,
        op_xor,
        op_slt,
        op_sltu,
        op_sll,
        op_srl,
        op_sra,
        op_lui,
        op_jal,
        op_jalr,
        op_beq,
        op_bne,
        op_blt,
        op_bge,
        op_load,
        op_store,
        op_ecall,
        op_ebreak,
        op_illegal,
        op_nop
    } op_t;

    //////////////////// exception causes

    // mcause encodings
    typedef enum logic [3:0] {
        cause_inst_misaligned  = 4'd0,
        cause_illegal          = 4'd2,
        cause_breakpoint       = 4'd3,
        cause_load_misaligned  = 4'd4,
        cause_store_misaligned = 4'd6,
        cause_ecall            = 4'd11
    } ecause_t;

    //////////////////// issued operation

    typedef struct packed {
        logic                 valid;
        op_t                  op;
        logic                 use_imm;  // operand b from imm
        logic [`XLEN-1:0]     pc;
        logic [`XLEN-1:0]     rs1;
        logic [`XLEN-1:0]     rs2;
        logic [`XLEN-1:0]     imm;
        logic [`REG_BITS-1:0] rd;
    } lane_req_t;

endpackage

//--- rtl/execute_settings.svh
`ifndef EXECUTE_SETTINGS_SVH
`define EXECUTE_SETTINGS_SVH

// datapath and pc width
`define XLEN 32

// register file address width
`define REG_BITS 5

// pc step from one instruction to the next
`define INSN_BYTES 4

`endif

//--- rtl/issue_merge.sv
`timescale 1ns/1ps
`include "execute_settings.svh"

module issue_merge (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    lane_result_if.merge          lane0,
    lane_result_if.merge          lane1,
    output logic                  out0_valid,
    output logic                  out0_wren,
    output logic [`REG_BITS-1:0]  out0_waddr,
    output logic [`XLEN-1:0]      out0_wdata,
    output logic                  out0_exception,
    output execute_pkg::ecause_t  out0_ecause,
    output logic                  out1_valid,
    output logic                  out1_wren,
    output logic [`REG_BITS-1:0]  out1_waddr,
    output logic [`XLEN-1:0]      out1_wdata,
    output logic                  out1_exception,
    output execute_pkg::ecause_t  out1_ecause,
    output logic                  redirect_valid,
    output logic [`XLEN-1:0]      redirect_pc
);

    logic             squash1;
    logic             next_redirect;
    logic [`XLEN-1:0] next_target;

    //////////////////// pairing

    // younger insn dies behind an older trap or a jump that skips over it
    assign squash1 = lane0.valid & (lane0.exception |
                     (lane0.jump & (lane1.npc == lane0.npc + `XLEN'(`INSN_BYTES))));

    assign next_redirect = lane0.jump | (lane1.jump & ~squash1);
    assign next_target = lane0.jump ? lane0.target : lane1.target;  // older wins

    //////////////////// stage register

    always_ff @(posedge clock) begin
        if (!reset || flush) begin
            out0_valid <= 1'b0;
            out0_wren <= 1'b0;
            out0_exception <= 1'b0;
            out1_valid <= 1'b0;
            out1_wren <= 1'b0;
            out1_exception <= 1'b0;
            redirect_valid <= 1'b0;
        end else if (!stall) begin
            out0_valid <= lane0.valid;
            out0_wren <= lane0.wren;
            out0_exception <= lane0.exception;
            out1_valid <= lane1.valid & ~squash1;
            out1_wren <= lane1.wren & ~squash1;
            out1_exception <= lane1.exception & ~squash1;
            redirect_valid <= next_redirect;
        end
    end

    // payload, qualified by the flags above
    always_ff @(posedge clock) begin
        if (!stall) begin
            out0_waddr <= lane0.waddr;
            out0_wdata <= lane0.wdata;
            out0_ecause <= lane0.ecause;
            out1_waddr <= lane1.waddr;
            out1_wdata <= lane1.wdata;
            out1_ecause <= lane1.ecause;
            redirect_pc <= next_target;
        end
    end

endmodule

//--- rtl/lane_result_if.sv
`timescale 1ns/1ps
`include "execute_settings.svh"

interface lane_result_if;
    import execute_pkg::*;

    logic                 valid;
    logic                 wren;
    logic [`REG_BITS-1:0] waddr;
    logic [`XLEN-1:0]     wdata;
    logic [`XLEN-1:0]     npc;       // pc of the next sequential insn
    logic                 jump;
    logic [`XLEN-1:0]     target;
    logic                 exception;
    ecause_t              ecause;

    modport lane (
        output valid, wren, waddr, wdata, npc, jump, target, exception, ecause
    );

    modport merge (
        input valid, wren, waddr, wdata, npc, jump, target, exception, ecause
    );

endinterface

//--- testbench/dual_execute_sva.sv
`timescale 1ns/1ps

module dual_execute_sva (
    input logic clock,
    input logic reset,
    input logic flush,
    input logic out0_valid,
    input logic out0_wren,
    input logic out0_exception,
    input logic out1_valid,
    input logic out1_wren,
    input logic out1_exception,
    input logic redirect_valid
);

    // a redirect always belongs to an issued insn
    redirect_has_owner: assert property (@(posedge clock) disable iff (!reset)
        redirect_valid |-> (out0_valid || out1_valid))
        else $error("redirect_valid without a valid output");

    flush_clears_outputs: assert property (@(posedge clock) disable iff (!reset)
        flush |=> (!out0_valid && !out1_valid))
        else $error("valid output in the cycle after a flush");

    no_write_on_trap: assert property (@(posedge clock) disable iff (!reset)
        !(out0_wren && out0_exception) && !(out1_wren && out1_exception))
        else $error("wren together with an exception");

endmodule

bind dual_execute dual_execute_sva sva_inst (.*);

//--- testbench/dual_execute_tb.sv
`timescale 1ns/1ps
`include "execute_settings.svh"

module dual_execute_tb;
    import execute_pkg::*;

    typedef struct packed {
        logic [6:0]       flags;  // v0 w0 e0 v1 w1 e1 redirect
        logic [`XLEN-1:0] d0, d1;
        ecause_t          c0, c1;
        logic [`XLEN-1:0] rpc;
    } exp_t;

    typedef struct packed {
        logic             v, w, e, j;
        ecause_t          c;
        logic [`XLEN-1:0] d, t;
    } lane_model_t;

    typedef struct {
        lane_req_t q0;
        lane_req_t q1;
        exp_t      x;
    } row_t;

    localparam ecause_t no_cause = cause_inst_misaligned;  // don't care
    localparam lane_req_t idle = '0;

    logic clock, reset, stall, flush;
    logic out0_valid, out0_wren, out0_exception;
    logic out1_valid, out1_wren, out1_exception;
    logic redirect_valid;
    logic [`REG_BITS-1:0] out0_waddr, out1_waddr;
    logic [`XLEN-1:0] out0_wdata, out1_wdata, redirect_pc;
    ecause_t out0_ecause, out1_ecause;
    lane_req_t r0, r1;
    logic [31:0] seed = 32'hc2c9_70c3;
    row_t rows[$];

    dual_execute dual_execute_inst (
        .*,
        .in0_valid(r0.valid), .in0_op(r0.op), .in0_use_imm(r0.use_imm), .in0_pc(r0.pc),
        .in0_rs1(r0.rs1), .in0_rs2(r0.rs2), .in0_imm(r0.imm), .in0_rd(r0.rd),
        .in1_valid(r1.valid), .in1_op(r1.op), .in1_use_imm(r1.use_imm), .in1_pc(r1.pc),
        .in1_rs1(r1.rs1), .in1_rs2(r1.rs2), .in1_imm(r1.imm), .in1_rd(r1.rd)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    initial begin
        reset = 1'b0;
        repeat (10) @(posedge clock);
        #1 reset = 1'b1;
    end

    //////////////////// stimulus helpers

    function automatic logic [31:0] lcg();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic lane_req_t rq(op_t op, logic [`XLEN-1:0] pc, rs1, rs2, imm,
                                     logic [`REG_BITS-1:0] rd, logic use_imm);
        return '{valid: 1'b1, op: op, use_imm: use_imm, pc: pc,
                 rs1: rs1, rs2: rs2, imm: imm, rd: rd};
    endfunction

    function automatic lane_req_t rand_req(logic [`XLEN-1:0] pc);
        lane_req_t q;
        logic [31:0] s;
        s = lcg();
        q.valid = (s[2:0] != 3'd0);
        q.op = op_t'(s[7:3] % 5'd23);
        q.use_imm = s[8];
        q.rd = s[13:9];
        q.pc = pc;
        q.rs1 = lcg();
        q.rs2 = s[14] ? q.rs1 : lcg();  // equal operands now and then
        q.imm = s[15] ? lcg() : {20'd0, s[27:16]};
        return q;
    endfunction

    //////////////////// reference model

    function automatic lane_model_t eval_lane(lane_req_t q);
        lane_model_t m;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] addr;
        logic taken;
        logic writes;
        b = q.use_imm ? q.imm : q.rs2;
        addr = q.rs1 + q.imm;
        taken = (q.op inside {op_jal, op_jalr}) || (q.op == op_beq && q.rs1 == q.rs2)
              || (q.op == op_bne && q.rs1 != q.rs2)
              || (q.op == op_blt && $signed(q.rs1) < $signed(q.rs2))
              || (q.op == op_bge && $signed(q.rs1) >= $signed(q.rs2));
        writes = q.op inside {op_add, op_sub, op_and, op_or, op_xor, op_slt, op_sltu,
                              op_sll, op_srl, op_sra, op_lui, op_jal, op_jalr};
        m.t = (q.op == op_jalr) ? (addr & ~32'd1) : q.pc + q.imm;
        case (q.op)
            op_add:  m.d = q.rs1 + b;
            op_sub:  m.d = q.rs1 - b;
            op_and:  m.d = q.rs1 & b;
            op_or:   m.d = q.rs1 | b;
            op_xor:  m.d = q.rs1 ^ b;
            op_slt:  m.d = {31'd0, $signed(q.rs1) < $signed(b)};
            op_sltu: m.d = {31'd0, q.rs1 < b};
            op_sll:  m.d = q.rs1 << b[4:0];
            op_srl:  m.d = q.rs1 >> b[4:0];
            op_sra:  m.d = $signed(q.rs1) >>> b[4:0];
            op_lui:  m.d = q.imm;
            op_jal, op_jalr: m.d = q.pc + 32'd4;
            op_load, op_store: m.d = addr;
            op_ecall, op_ebreak, op_illegal: m.d = q.pc;
            default: m.d = '0;
        endcase
        m.e = 1'b1;
        m.c = cause_inst_misaligned;
        if (q.op == op_illegal) m.c = cause_illegal;
        else if (q.op == op_ebreak) m.c = cause_breakpoint;
        else if (q.op == op_ecall) m.c = cause_ecall;
        else if (q.op == op_load && addr[1:0] != 2'b00) m.c = cause_load_misaligned;
        else if (q.op == op_store && addr[1:0] != 2'b00) m.c = cause_store_misaligned;
        else if (taken && m.t[1]) m.c = cause_inst_misaligned;
        else m.e = 1'b0;
        m.v = q.valid;
        m.w = q.valid && writes && !m.e && q.rd != '0;
        m.j = q.valid && taken && !m.e;
        m.e = q.valid && m.e;
        return m;
    endfunction

    function automatic exp_t model(lane_req_t q0, lane_req_t q1);
        lane_model_t a;
        lane_model_t b;
        logic squash;
        exp_t x;
        a = eval_lane(q0);
        b = eval_lane(q1);
        // younger insn dies behind an older trap or a jump over it
        squash = a.v && (a.e || (a.j && q1.pc == q0.pc + 32'd4));
        x.flags = {a.v, a.w, a.e, b.v && !squash, b.w && !squash, b.e && !squash,
                   a.j || (b.j && !squash)};
        x.d0 = a.d;
        x.d1 = b.d;
        x.c0 = a.c;
        x.c1 = b.c;
        x.rpc = a.j ? a.t : b.t;
        return x;
    endfunction

    function automatic logic has_data(op_t op);
        return !(op inside {op_beq, op_bne, op_blt, op_bge, op_nop});
    endfunction

    //////////////////// checks

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
        if (got !== want) begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, name, got, want);
            stop_run();
        end
    endtask

    task automatic compare_outputs(lane_req_t q0, lane_req_t q1, exp_t x);
        check_value("out0_valid", out0_valid, x.flags[6]);
        check_value("out0_wren", out0_wren, x.flags[5]);
        check_value("out0_exception", out0_exception, x.flags[4]);
        check_value("out1_valid", out1_valid, x.flags[3]);
        check_value("out1_wren", out1_wren, x.flags[2]);
        check_value("out1_exception", out1_exception, x.flags[1]);
        check_value("redirect_valid", redirect_valid, x.flags[0]);
        if (x.flags[6]) check_value("out0_waddr", out0_waddr, q0.rd);
        if (x.flags[6] && has_data(q0.op)) check_value("out0_wdata", out0_wdata, x.d0);
        if (x.flags[4]) check_value("out0_ecause", out0_ecause, x.c0);
        if (x.flags[3]) check_value("out1_waddr", out1_waddr, q1.rd);
        if (x.flags[3] && has_data(q1.op)) check_value("out1_wdata", out1_wdata, x.d1);
        if (x.flags[1]) check_value("out1_ecause", out1_ecause, x.c1);
        if (x.flags[0]) check_value("redirect_pc", redirect_pc, x.rpc);
    endtask

    // drive 1 ns after the edge, look one edge later
    task automatic step(lane_req_t q0, lane_req_t q1, exp_t x);
        r0 = q0;
        r1 = q1;
        @(posedge clock);
        #1;
        compare_outputs(q0, q1, x);
    endtask

    task automatic add_row(lane_req_t q0, lane_req_t q1, exp_t x);
        rows.push_back('{q0, q1, x});
    endtask

    //////////////////// directed pairs

    task automatic load_rows();
        add_row(rq(op_add, 'h100, 5, 7, 0, 3, 0), rq(op_sub, 'h104, 20, 0, 6, 4, 1),
                '{7'b110_110_0, 12, 14, no_cause, no_cause, 0});
        add_row(rq(op_sra, 'h110, 'hf000_0000, 0, 4, 5, 1), rq(op_slt, 'h114, -1, 1, 0, 6, 0),
                '{7'b110_110_0, 'hff00_0000, 1, no_cause, no_cause, 0});
        add_row(rq(op_lui, 'h120, 0, 0, 'h1234_5000, 0, 1), rq(op_sltu, 'h124, 1, -1, 0, 7, 0),
                '{7'b100_110_0, 'h1234_5000, 1, no_cause, no_cause, 0});
        add_row(rq(op_beq, 'h200, 9, 9, 'h40, 0, 0), rq(op_or, 'h204, 1, 2, 0, 8, 0),
                '{7'b100_000_1, 0, 0, no_cause, no_cause, 'h240});
        add_row(rq(op_bne, 'h300, 4, 4, 'h20, 0, 0), rq(op_jal, 'h304, 0, 0, 'h100, 1, 0),
                '{7'b100_110_1, 0, 'h308, no_cause, no_cause, 'h404});
        add_row(rq(op_jalr, 'h400, 'h1001, 0, 'h10, 2, 1), rq(op_add, 'h800, 1, 1, 0, 3, 0),
                '{7'b110_110_1, 'h404, 2, no_cause, no_cause, 'h1010});
        add_row(rq(op_blt, 'h500, -16, 5, 8, 0, 0), rq(op_bge, 'h508, 3, 3, 'h10, 0, 0),
                '{7'b100_100_1, 0, 0, no_cause, no_cause, 'h508});
        add_row(rq(op_jal, 'h600, 0, 0, 2, 1, 0), rq(op_add, 'h604, 1, 1, 0, 3, 0),
                '{7'b101_000_0, 'h604, 0, cause_inst_misaligned, no_cause, 0});
        add_row(rq(op_load, 'h700, 'h1000, 0, 8, 5, 1), rq(op_store, 'h704, 'h1000, 0, 6, 0, 1),
                '{7'b100_101_0, 'h1008, 'h1006, no_cause, cause_store_misaligned, 0});
        add_row(rq(op_load, 'h710, 'h1001, 0, 0, 5, 1), rq(op_add, 'h714, 1, 1, 0, 3, 0),
                '{7'b101_000_0, 'h1001, 0, cause_load_misaligned, no_cause, 0});
        add_row(rq(op_ecall, 'h720, 0, 0, 0, 0, 0), rq(op_add, 'h724, 1, 1, 0, 3, 0),
                '{7'b101_000_0, 'h720, 0, cause_ecall, no_cause, 0});
        add_row(idle, rq(op_ebreak, 'h734, 0, 0, 0, 0, 0),
                '{7'b000_101_0, 0, 'h734, no_cause, cause_breakpoint, 0});
        add_row(rq(op_xor, 'h740, 'hff00, 0, 'h0ff0, 9, 1), rq(op_illegal, 'h744, 0, 0, 0, 0, 0),
                '{7'b110_101_0, 'hf0f0, 'h744, no_cause, cause_illegal, 0});
        add_row(idle, idle, '{7'b000_000_0, 0, 0, no_cause, no_cause, 0});
    endtask

    initial begin
        int waited;
        lane_req_t a0;
        lane_req_t a1;
        logic [`XLEN-1:0] pc;
        stall = 1'b0;
        flush = 1'b0;
        load_rows();
        // a live pair while reset is low must not reach the outputs
        r0 = rows[4].q0;
        r1 = rows[4].q1;
        waited = 0;
        @(posedge clock);
        while (reset !== 1'b1) begin
            #1;
            compare_outputs(idle, idle, model(idle, idle));
            @(posedge clock);
            waited++;
            if (waited > 20) begin
                $display("reset was never released");
                stop_run();
            end
        end
        #1;
        compare_outputs(rows[4].q0, rows[4].q1, rows[4].x);

        foreach (rows[i]) step(rows[i].q0, rows[i].q1, rows[i].x);

        // stall holds the stage, new pair waits upstream
        step(rows[4].q0, rows[4].q1, rows[4].x);
        stall = 1'b1;
        r0 = rows[0].q0;
        r1 = rows[0].q1;
        repeat (3) begin
            @(posedge clock);
            #1;
            compare_outputs(rows[4].q0, rows[4].q1, rows[4].x);
        end
        stall = 1'b0;
        step(rows[0].q0, rows[0].q1, rows[0].x);
        flush = 1'b1;
        stall = 1'b1;  // flush wins over stall
        step(rows[4].q0, rows[4].q1, model(idle, idle));
        flush = 1'b0;
        stall = 1'b0;

        //////////////////// random pairs
        repeat (200) begin
            pc = lcg() & 32'hffff_fffc;
            a0 = rand_req(pc);
            a1 = rand_req(seed[20] ? pc + 32'd4 : lcg() & 32'hffff_fffc);
            step(a0, a1, model(a0, a1));
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule
